/* project.f */
design/mem_pkg.sv
design/fill_pkg.sv
design/mem_arbiter.sv
design/word_mem.sv
design/rect_fill.sv
design/mem_test.sv
design/mem_sys_top.sv
sim/mem_sys_properties.sv
sim/tb_mem_sys.sv

/* sim/tb_mem_sys.sv */
// Testbench for mem_sys_top with host table, LCG data, check task and watchdog
`timescale 1ns/1ps

module tb_mem_sys;

localparam int N_ENTRIES = 24;
localparam int AREA_WORDS = (6 + 2) * (3 + 2);
localparam int TEST_WORDS = 16;
localparam int WATCHDOG_CYCLES = (N_ENTRIES + AREA_WORDS + TEST_WORDS) * 20;
localparam logic [15:0] FILL = 16'h0841;
localparam logic [15:0] KEY = 16'hA5C3;
localparam logic [11:0] TABLE_ADDR [8] = '{12'h100, 12'h1FF, 12'h3A5, 12'h555,
	12'h7FF, 12'hFFF, 12'h400, 12'hC3C};

logic CLOCK_50 = 1'b0;
logic rst;
logic host_req;
logic host_wr;
logic [11:0] host_addr;
logic [15:0] host_wdata;
logic host_ack;
logic host_valid;
logic [15:0] host_rdata;
logic rect_start;
logic rect_active;
logic test_start;
logic test_verify_only;
logic test_busy;
logic test_done;
logic test_fail;

string tab_name [N_ENTRIES];
logic [11:0] tab_addr [N_ENTRIES];
logic [15:0] tab_wdata [N_ENTRIES];
logic [15:0] tab_exp [N_ENTRIES];
logic tab_wr [N_ENTRIES];
logic [15:0] shadow [logic [11:0]];
logic [31:0] lcg_state = 32'h8acd6423;

mem_sys_top u_dut (.*);

always #20 CLOCK_50 = ~CLOCK_50;

function automatic logic [31:0] lcg_next(logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [15:0] test_word(logic [11:0] a);
	return {4'h0, a} ^ KEY;
endfunction

// Background around the box changes with every address bit
function automatic logic [15:0] background(logic [11:0] a);
	return 16'h5A5A ^ {a, 4'h0} ^ {4'h0, a};
endfunction

function automatic logic [11:0] fb_addr(int x, int y);
	return 12'(y * 32 + x);
endfunction

function automatic bit in_box(int x, int y);
	return x >= 4 && x < 10 && y >= 2 && y < 5;
endfunction

task automatic check(string name, logic [15:0] expected, logic [15:0] actual);
	if (actual !== expected) begin
		$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		$display(">>> FAIL");
		$fatal(1, "Check failed");
	end
endtask

// Writes first, then reads, then rewrites of four addresses and their reads
task automatic build_table();
	int k;
	for (int i = 0; i < N_ENTRIES; i++) begin
		k = (i < 16) ? i % 8 : i % 4;
		tab_addr[i] = TABLE_ADDR[k];
		tab_wr[i] = (i < 8) || (i >= 16 && i < 20);
		tab_name[i] = $sformatf("%s_%03h_%0d", tab_wr[i] ? "wr" : "rd", tab_addr[i], i);
		tab_wdata[i] = '0;
		tab_exp[i] = '0;
		if (tab_wr[i]) begin
			lcg_state = lcg_next(lcg_state);
			tab_wdata[i] = lcg_state[31:16];
			shadow[tab_addr[i]] = tab_wdata[i];
		end else begin
			tab_exp[i] = shadow[tab_addr[i]];
		end
	end
endtask

// Called 2 ns after a rising edge and returns 2 ns into the ack cycle
task automatic host_access(logic wr, logic [11:0] a, logic [15:0] d);
	host_req = 1'b1;
	host_wr = wr;
	host_addr = a;
	host_wdata = d;
	do begin
		@(posedge CLOCK_50);
		#2;
	end while (!host_ack);
	host_req = 1'b0;
endtask

// Read data must show up exactly two cycles after the ack
task automatic read_check(string name, logic [11:0] a, logic [15:0] exp);
	host_access(1'b0, a, '0);
	@(posedge CLOCK_50);
	#2;
	check({name, "_valid_early"}, 16'd0, 16'(host_valid));
	@(posedge CLOCK_50);
	#2;
	check({name, "_valid"}, 16'd1, 16'(host_valid));
	check(name, exp, host_rdata);
endtask

// Background over the box and a margin of one word around it
task automatic paint_background();
	for (int y = 1; y <= 5; y++) begin
		for (int x = 3; x <= 10; x++) begin
			host_access(1'b1, fb_addr(x, y), background(fb_addr(x, y)));
		end
	end
endtask

// Inverted test words over the whole test region
task automatic scramble_test_region();
	logic [11:0] a;
	for (int i = 0; i < TEST_WORDS; i++) begin
		a = 12'h800 + 12'(i);
		host_access(1'b1, a, ~test_word(a));
	end
endtask

task automatic check_area();
	logic [11:0] a;
	for (int y = 1; y <= 5; y++) begin
		for (int x = 3; x <= 10; x++) begin
			a = fb_addr(x, y);
			read_check($sformatf("rect_%0d_%0d", x, y), a, in_box(x, y) ? FILL : background(a));
		end
	end
endtask

task automatic check_test_region();
	logic [11:0] a;
	for (int i = 0; i < TEST_WORDS; i++) begin
		a = 12'h800 + 12'(i);
		read_check($sformatf("test_word_%03h", a), a, test_word(a));
	end
endtask

task automatic wait_test_done();
	while (!test_done) begin
		@(posedge CLOCK_50);
		#2;
	end
endtask

task automatic run_test(logic verify_only);
	test_verify_only = verify_only;
	test_start = 1'b1;
	@(posedge CLOCK_50);
	#2;
	test_start = 1'b0;
	check("test_busy_rise", 16'd1, 16'(test_busy));
	wait_test_done();
endtask

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50);
	$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
	$display(">>> FAIL");
	$fatal(1, "Watchdog expired");
end

initial begin
	rst = 1'b1;
	host_req = 1'b0;
	host_wr = 1'b0;
	host_addr = '0;
	host_wdata = '0;
	rect_start = 1'b0;
	test_start = 1'b0;
	test_verify_only = 1'b0;
	build_table();
	repeat (2) @(posedge CLOCK_50);
	#2;
	rst = 1'b0;
	check("reset_outputs", 16'd0,
		16'({host_ack, host_valid, rect_active, test_busy, test_done, test_fail}));

	for (int i = 0; i < N_ENTRIES; i++) begin
		if (tab_wr[i]) begin
			host_access(1'b1, tab_addr[i], tab_wdata[i]);
		end else begin
			read_check(tab_name[i], tab_addr[i], tab_exp[i]);
		end
	end

	paint_background();
	rect_start = 1'b1;
	@(posedge CLOCK_50);
	#2;
	rect_start = 1'b0;
	check("rect_active_rise", 16'd1, 16'(rect_active));
	while (rect_active) begin
		@(posedge CLOCK_50);
		#2;
	end
	check_area();

	run_test(1'b0);
	check("test_fail_full", 16'd0, 16'(test_fail));
	check_test_region();

	host_access(1'b1, 12'h805, test_word(12'h805) ^ 16'h0100);
	run_test(1'b1);
	check("test_fail_fault", 16'd1, 16'(test_fail));
	run_test(1'b0);
	check("test_fail_cleared", 16'd0, 16'(test_fail));

	// Both engines and host reads compete for the memory
	paint_background();
	scramble_test_region();
	test_verify_only = 1'b0;
	rect_start = 1'b1;
	test_start = 1'b1;
	@(posedge CLOCK_50);
	#2;
	rect_start = 1'b0;
	test_start = 1'b0;
	for (int i = 8; i < 16; i++) begin
		read_check({tab_name[i], "_busy"}, tab_addr[i], shadow[tab_addr[i]]);
	end
	while (rect_active) begin
		@(posedge CLOCK_50);
		#2;
	end
	wait_test_done();
	check("test_fail_contention", 16'd0, 16'(test_fail));
	check_area();
	check_test_region();

	if (u_dut.u_arb.u_props.fail_count == 0) begin
		$display(">>> PASS");
		$finish;
	end else begin
		$display("Arbiter handshake assertions failed during the run");
		$display(">>> FAIL");
		$fatal(1, "Assertion failures");
	end
end

endmodule

/* sim/mem_sys_properties.sv */
// Concurrent assertions on the arbiter ack, valid and memory command handshake, with bind
`timescale 1ns/1ps

module mem_arbiter_properties (
	input logic CLOCK_50,
	input logic rst,
	input logic [mem_pkg::CLIENTS-1:0] client_req,
	input logic [mem_pkg::CLIENTS-1:0] client_ack,
	input logic [mem_pkg::CLIENTS-1:0] client_valid,
	input logic mem_en
);

// Number of failed assertions
int unsigned fail_count = 0;

ack_onehot: assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(client_ack))
	else begin
		$error("More than one client acknowledged in one cycle");
		fail_count++;
	end

// Ack is registered from the request seen one edge earlier
ack_requested: assert property (@(posedge CLOCK_50) disable iff (rst)
	(client_ack & ~$past(client_req)) == '0)
	else begin
		$error("Ack given to a client that was not requesting");
		fail_count++;
	end

// Valid only for a client acknowledged RD_LATENCY cycles earlier
valid_onehot: assert property (@(posedge CLOCK_50) disable iff (rst)
	$onehot0(client_valid)
	&& (client_valid & ~$past(client_ack, mem_pkg::RD_LATENCY)) == '0)
	else begin
		$error("Client valid not one-hot or without an ack two cycles earlier");
		fail_count++;
	end

en_matches_ack: assert property (@(posedge CLOCK_50) disable iff (rst) mem_en == |client_ack)
	else begin
		$error("Memory enable does not match the acks");
		fail_count++;
	end

quiet_after_reset: assert property (@(posedge CLOCK_50)
	rst |=> (client_ack == '0 && client_valid == '0))
	else begin
		$error("Ack or valid high in the cycle after reset");
		fail_count++;
	end

endmodule

bind mem_arbiter mem_arbiter_properties u_props (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.client_req(client_req),
	.client_ack(client_ack),
	.client_valid(client_valid),
	.mem_en(mem_en)
);

/* design/mem_sys_top.sv */
// Memory subsystem top with host port, fill and test clients, arbiter and memory
`timescale 1ns/1ps

module mem_sys_top #(
	parameter mem_pkg::addr_t FB_BASE = 12'h000,
	parameter int LINE_STRIDE = 32,
	parameter fill_pkg::coord_t RECT_X = 9'd4,
	parameter fill_pkg::coord_t RECT_Y = 9'd2,
	parameter fill_pkg::coord_t RECT_W = 9'd6,
	parameter fill_pkg::coord_t RECT_H = 9'd3,
	parameter mem_pkg::data_t FILL_COLOR = 16'h0841,
	parameter mem_pkg::addr_t TEST_BASE = 12'h800,
	parameter int TEST_LEN = 16
) (
	input logic CLOCK_50,
	input logic rst,
	input logic host_req,
	input logic host_wr,
	input mem_pkg::addr_t host_addr,
	input mem_pkg::data_t host_wdata,
	output logic host_ack,
	output mem_pkg::data_t host_rdata,
	output logic host_valid,
	input logic rect_start,
	output logic rect_active,
	input logic test_start,
	input logic test_verify_only,
	output logic test_busy,
	output logic test_done,
	output logic test_fail
);

logic [mem_pkg::CLIENTS-1:0] client_req;
logic [mem_pkg::CLIENTS-1:0] client_wr;
logic [mem_pkg::CLIENTS-1:0] client_ack;
logic [mem_pkg::CLIENTS-1:0] client_valid;
mem_pkg::addr_t client_addr [mem_pkg::CLIENTS];
mem_pkg::data_t client_wdata [mem_pkg::CLIENTS];
mem_pkg::data_t rdata;

logic mem_en;
logic mem_wr;
mem_pkg::addr_t mem_addr;
mem_pkg::data_t mem_wdata;
mem_pkg::data_t mem_rdata;

// Host port is client 0
assign client_req[mem_pkg::CL_HOST] = host_req;
assign client_wr[mem_pkg::CL_HOST] = host_wr;
assign client_addr[mem_pkg::CL_HOST] = host_addr;
assign client_wdata[mem_pkg::CL_HOST] = host_wdata;
assign host_ack = client_ack[mem_pkg::CL_HOST];
assign host_valid = client_valid[mem_pkg::CL_HOST];
assign host_rdata = rdata;

rect_fill #(
	.FB_BASE(FB_BASE),
	.LINE_STRIDE(LINE_STRIDE),
	.RECT_X(RECT_X),
	.RECT_Y(RECT_Y),
	.RECT_W(RECT_W),
	.RECT_H(RECT_H),
	.FILL_COLOR(FILL_COLOR)
) u_rect (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(rect_start),
	.active(rect_active),
	.req(client_req[mem_pkg::CL_RECT]),
	.wr(client_wr[mem_pkg::CL_RECT]),
	.addr(client_addr[mem_pkg::CL_RECT]),
	.wdata(client_wdata[mem_pkg::CL_RECT]),
	.ack(client_ack[mem_pkg::CL_RECT])
);

mem_test #(
	.TEST_BASE(TEST_BASE),
	.TEST_LEN(TEST_LEN)
) u_test (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(test_start),
	.verify_only(test_verify_only),
	.busy(test_busy),
	.done(test_done),
	.fail(test_fail),
	.req(client_req[mem_pkg::CL_TEST]),
	.wr(client_wr[mem_pkg::CL_TEST]),
	.addr(client_addr[mem_pkg::CL_TEST]),
	.wdata(client_wdata[mem_pkg::CL_TEST]),
	.ack(client_ack[mem_pkg::CL_TEST]),
	.rdata(rdata),
	.valid(client_valid[mem_pkg::CL_TEST])
);

mem_arbiter u_arb (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.client_req(client_req),
	.client_wr(client_wr),
	.client_addr(client_addr),
	.client_wdata(client_wdata),
	.client_ack(client_ack),
	.client_valid(client_valid),
	.rdata(rdata),
	.mem_en(mem_en),
	.mem_wr(mem_wr),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_rdata(mem_rdata)
);

word_mem u_mem (
	.CLOCK_50(CLOCK_50),
	.mem_en(mem_en),
	.mem_wr(mem_wr),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_rdata(mem_rdata)
);

endmodule

/* design/mem_test.sv */
// Write-then-verify memory test client with a sticky fail flag
`timescale 1ns/1ps

module mem_test #(
	parameter mem_pkg::addr_t TEST_BASE = 12'h800,
	parameter int TEST_LEN = 16
) (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input logic verify_only,
	output logic busy,
	output logic done,
	output logic fail,
	output logic req,
	output logic wr,
	output mem_pkg::addr_t addr,
	output mem_pkg::data_t wdata,
	input logic ack,
	input mem_pkg::data_t rdata,
	input logic valid
);

fill_pkg::test_state_e state;
mem_pkg::addr_t issue_cnt;
mem_pkg::addr_t ret_cnt;
logic [3:0] outstanding;
logic last_issue;
logic rd_ack;

// Expected word for an address
function automatic mem_pkg::data_t pattern(mem_pkg::addr_t a);
	return mem_pkg::data_t'(a) ^ fill_pkg::PATTERN_KEY;
endfunction

assign addr = TEST_BASE + issue_cnt;
assign wdata = pattern(addr);
assign req = (state == fill_pkg::test_write) || (state == fill_pkg::test_read);
assign wr = (state == fill_pkg::test_write);
assign busy = req || (state == fill_pkg::test_drain);
assign done = (state == fill_pkg::test_done);
assign last_issue = (issue_cnt == mem_pkg::addr_t'(TEST_LEN - 1));
assign rd_ack = ack && (state == fill_pkg::test_read);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= fill_pkg::test_idle;
		issue_cnt <= '0;
		ret_cnt <= '0;
		outstanding <= '0;
		fail <= 1'b0;
	end else begin
		outstanding <= outstanding + 4'(rd_ack) - 4'(valid);

		// Results come back in issue order
		if (valid) begin
			ret_cnt <= ret_cnt + 1'b1;
			if (rdata != pattern(TEST_BASE + ret_cnt)) begin
				fail <= 1'b1;
			end
		end

		case (state)
			fill_pkg::test_idle, fill_pkg::test_done: begin
				if (start) begin
					issue_cnt <= '0;
					ret_cnt <= '0;
					fail <= 1'b0;
					if (verify_only) begin
						state <= fill_pkg::test_read;
					end else begin
						state <= fill_pkg::test_write;
					end
				end
			end
			fill_pkg::test_write: begin
				if (ack) begin
					if (last_issue) begin
						issue_cnt <= '0;
						state <= fill_pkg::test_read;
					end else begin
						issue_cnt <= issue_cnt + 1'b1;
					end
				end
			end
			// Reads go out back to back
			fill_pkg::test_read: begin
				if (ack) begin
					if (last_issue) begin
						state <= fill_pkg::test_drain;
					end else begin
						issue_cnt <= issue_cnt + 1'b1;
					end
				end
			end
			// Wait for the last read in flight
			fill_pkg::test_drain: begin
				if (valid && outstanding == 4'd1) begin
					state <= fill_pkg::test_done;
				end
			end
			default: state <= fill_pkg::test_idle;
		endcase
	end
end

endmodule

/* design/rect_fill.sv */
// Rectangle fill client writing one colour over a box of the frame buffer
`timescale 1ns/1ps

module rect_fill #(
	parameter mem_pkg::addr_t FB_BASE = '0,
	parameter int LINE_STRIDE = 32,
	parameter fill_pkg::coord_t RECT_X = '0,
	parameter fill_pkg::coord_t RECT_Y = '0,
	parameter fill_pkg::coord_t RECT_W = 9'd1,
	parameter fill_pkg::coord_t RECT_H = 9'd1,
	parameter mem_pkg::data_t FILL_COLOR = '0
) (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	output logic active,
	output logic req,
	output logic wr,
	output mem_pkg::addr_t addr,
	output mem_pkg::data_t wdata,
	input logic ack
);

fill_pkg::fill_state_e state;
fill_pkg::coord_t col;
fill_pkg::coord_t row;
logic last_col;
logic last_pixel;

assign active = (state != fill_pkg::fill_idle);
assign req = (state == fill_pkg::fill_write_pixel);
assign wr = 1'b1;
assign wdata = FILL_COLOR;

// Line-strided pixel address
assign addr = mem_pkg::addr_t'(int'(FB_BASE)
	+ (int'(RECT_Y) + int'(row)) * LINE_STRIDE
	+ int'(RECT_X) + int'(col));

assign last_col = (col == RECT_W - 1'b1);
assign last_pixel = last_col && (row == RECT_H - 1'b1);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= fill_pkg::fill_idle;
		col <= '0;
		row <= '0;
	end else begin
		case (state)
			fill_pkg::fill_idle: begin
				if (start) begin
					col <= '0;
					row <= '0;
					state <= fill_pkg::fill_write_pixel;
				end
			end
			fill_pkg::fill_write_pixel: begin
				if (ack) begin
					if (last_pixel) begin
						state <= fill_pkg::fill_idle;
					end else begin
						state <= fill_pkg::fill_next_pixel;
					end
				end
			end
			// Column first, then the next line
			fill_pkg::fill_next_pixel: begin
				if (last_col) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
				state <= fill_pkg::fill_write_pixel;
			end
			default: state <= fill_pkg::fill_idle;
		endcase
	end
end

endmodule

/* design/word_mem.sv */
// On-chip word memory with registered command and registered read data
`timescale 1ns/1ps

module word_mem (
	input logic CLOCK_50,
	input logic mem_en,
	input logic mem_wr,
	input mem_pkg::addr_t mem_addr,
	input mem_pkg::data_t mem_wdata,
	output mem_pkg::data_t mem_rdata
);

localparam int DEPTH = 2 ** $bits(mem_pkg::addr_t);
localparam int OUT_STAGES = mem_pkg::RD_LATENCY - 1;

mem_pkg::data_t mem [DEPTH];
logic rd_en_q;
mem_pkg::addr_t rd_addr_q;
mem_pkg::data_t out_q [OUT_STAGES];

// Command sampled here, write lands on the same edge
always_ff @(posedge CLOCK_50) begin
	if (mem_en && mem_wr) begin
		mem[mem_addr] <= mem_wdata;
	end
	rd_en_q <= mem_en & ~mem_wr;
	rd_addr_q <= mem_addr;
end

// Array read one edge later, old data on a same-edge write
always_ff @(posedge CLOCK_50) begin
	if (rd_en_q) begin
		out_q[0] <= mem[rd_addr_q];
	end
	for (int i = 1; i < OUT_STAGES; i++) begin
		out_q[i] <= out_q[i-1];
	end
end

assign mem_rdata = out_q[OUT_STAGES-1];

endmodule

/* design/mem_arbiter.sv */
// Round-robin memory arbiter with registered command and read-return tag pipeline
`timescale 1ns/1ps

module mem_arbiter (
	input logic CLOCK_50,
	input logic rst,
	input logic [mem_pkg::CLIENTS-1:0] client_req,
	input logic [mem_pkg::CLIENTS-1:0] client_wr,
	input mem_pkg::addr_t client_addr [mem_pkg::CLIENTS],
	input mem_pkg::data_t client_wdata [mem_pkg::CLIENTS],
	output logic [mem_pkg::CLIENTS-1:0] client_ack,
	output logic [mem_pkg::CLIENTS-1:0] client_valid,
	output mem_pkg::data_t rdata,
	output logic mem_en,
	output logic mem_wr,
	output mem_pkg::addr_t mem_addr,
	output mem_pkg::data_t mem_wdata,
	input mem_pkg::data_t mem_rdata
);

localparam int LAT = mem_pkg::RD_LATENCY;

logic [mem_pkg::CLIENTS-1:0] eligible;
logic grant_any;
mem_pkg::cl_idx_t grant_idx;
mem_pkg::cl_idx_t last_q;
mem_pkg::cl_idx_t cur_q;
logic [LAT-1:0] tag_v;
mem_pkg::cl_idx_t tag_id [LAT];

// Client still holds req during its ack cycle
assign eligible = client_req & ~client_ack;

// Search starts just after the last client served
always_comb begin
	int idx;
	grant_any = 1'b0;
	grant_idx = last_q;
	for (int k = 1; k <= mem_pkg::CLIENTS; k++) begin
		idx = (int'(last_q) + k) % mem_pkg::CLIENTS;
		if (!grant_any && eligible[idx]) begin
			grant_any = 1'b1;
			grant_idx = mem_pkg::cl_idx_t'(idx);
		end
	end
end

// Ack and memory command leave on the same edge
always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		client_ack <= '0;
		mem_en <= 1'b0;
		mem_wr <= 1'b0;
		last_q <= mem_pkg::cl_idx_t'(mem_pkg::CLIENTS - 1);
	end else begin
		client_ack <= '0;
		mem_en <= grant_any;
		if (grant_any) begin
			client_ack[grant_idx] <= 1'b1;
			mem_wr <= client_wr[grant_idx];
			last_q <= grant_idx;
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (grant_any) begin
		mem_addr <= client_addr[grant_idx];
		mem_wdata <= client_wdata[grant_idx];
		cur_q <= grant_idx;
	end
end

// Read tags follow the memory pipeline
always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		tag_v <= '0;
	end else begin
		tag_v <= {tag_v[LAT-2:0], mem_en & ~mem_wr};
	end
end

always_ff @(posedge CLOCK_50) begin
	tag_id[0] <= cur_q;
	for (int i = 1; i < LAT; i++) begin
		tag_id[i] <= tag_id[i-1];
	end
end

// Tag at the end of the pipe selects the receiving client
always_comb begin
	client_valid = '0;
	if (tag_v[LAT-1]) begin
		client_valid[tag_id[LAT-1]] = 1'b1;
	end
end

assign rdata = mem_rdata;

endmodule

/* design/fill_pkg.sv */
// Client-side geometry type, test pattern key and engine state enums
package fill_pkg;

// Pixel position or length
typedef logic [8:0] coord_t;

// Test word is the zero-extended address XOR this key
localparam mem_pkg::data_t PATTERN_KEY = 16'hA5C3;

// Rectangle fill engine
typedef enum logic [1:0] {
	fill_idle,
	fill_write_pixel,
	fill_next_pixel
} fill_state_e;

// Memory test engine
typedef enum logic [2:0] {
	test_idle,
	test_write,
	test_read,
	test_drain,
	test_done
} test_state_e;

endpackage

/* design/mem_pkg.sv */
// Memory word and address types, arbiter client indices and read latency
package mem_pkg;

// One word per address, no byte lanes
typedef logic [11:0] addr_t;
typedef logic [15:0] data_t;

// Arbiter clients
localparam int CLIENTS = 3;
typedef logic [$clog2(CLIENTS)-1:0] cl_idx_t;

localparam int CL_HOST = 0;
localparam int CL_RECT = 1;
localparam int CL_TEST = 2;

// Cycles from ack to read data at the client
localparam int RD_LATENCY = 2;

endpackage
